//--- conv_top.f
src/conv_pkg.sv
src/conv_decode.sv
src/conv_buffers.sv
src/conv_addr_gen.sv
src/conv_pe_array.sv
src/conv_result.sv
src/conv_top.sv
sim/conv_props.sv
sim/conv_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f conv_top.f &&
./obj_dir/Vconv_tb | tee /dev/stderr | grep -x '>>> PASS' > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sim/conv_patterns.txt
# C opcode addr data : command in hex, opcode 1 ifm, 2 weight, 3 shape, 4 start
# E index word : expected output in hex, W : wait for done_compute and compare
C 1 000 03FB140A
C 1 001 060CF804
C 1 002 010907FD
C 1 003 0BFC0210
C 1 004 05050505
C 2 000 00000408
C 2 001 00080004
C 2 002 0C000000
C 2 040 00002828
C 2 041 1414F600
C 2 042 28282828
C 2 080 000500F6
C 2 081 F6000000
C 2 082 FBFBFBFB
C 2 0C0 0401FE03
C 2 0C1 FD0205FF
C 2 0C2 02FA0006
C 3 000 00000C0D
C 4 000 00000000
# both land while busy and must be dropped
C 1 003 7F7F7F7F
C 3 000 00000405
E 00 00006011
E 01 10003C0C
E 02 00004306
W
C 3 000 0000080A
C 4 000 00000000
E 00 00006011
E 01 00001102
W

//--- sim/conv_tb.sv
`timescale 1ns/10ps

module conv_tb;
    import conv_pkg::*;

    logic        clk;
    logic        arst_n;
    cmd_t        cmd;
    logic        cmd_valid;
    logic        ofm_valid;
    ofm_word_t   ofm_data;
    logic [6:0]  ofm_index;
    logic        busy;
    logic        done_compute;
    integer      seed = 32'hce0d;
    int          value_errors;
    int          other_errors;
    int          runs;
    int          done_count;
    int          done_size;
    logic        prev_valid;
    logic [31:0] got_data[$];
    logic [6:0]  got_index[$];
    logic [31:0] exp_data[$];
    logic [6:0]  exp_index[$];

    conv_top DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .ofm_valid    (ofm_valid),
        .ofm_data     (ofm_data),
        .ofm_index    (ofm_index),
        .busy         (busy),
        .done_compute (done_compute)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic send_cmd(input logic [2:0] op, input logic [10:0] addr,
                            input logic [31:0] data);
        cmd_t c;
        int   gap;
        c.opcode = opcode_e'(op);
        c.addr   = addr;
        c.data   = data;
        @(posedge clk);
        cmd       <= c;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;
        // idle gap of 0 to 3 cycles
        gap = {$random(seed)} % 4;
        repeat (gap) @(posedge clk);
    endtask

    task automatic wait_done(output logic timed_out);
        int n;
        n = 0;
        // runs here finish well inside 200 cycles
        while (done_count < runs && n < 200) begin
            @(posedge clk);
            n++;
        end
        timed_out = (done_count < runs);
        if (timed_out) begin
            other_errors++;
            $display("timeout: run %0d gave no done_compute within 200 cycles", runs);
        end
    endtask

    task automatic compare_run();
        // a few idle cycles so a stray strobe would be counted
        repeat (4) @(posedge clk);
        check_value("done_compute count", done_count, runs);
        check_value("ofm_valid count", got_data.size(), exp_data.size());
        check_value("ofm_valid count at done_compute", done_size, exp_data.size());
        while (got_data.size() > 0 && exp_data.size() > 0) begin
            check_value("ofm_index", got_index.pop_front(), exp_index.pop_front());
            check_value("ofm_data", got_data.pop_front(), exp_data.pop_front());
        end
        got_data.delete();
        got_index.delete();
        exp_data.delete();
        exp_index.delete();
    endtask

    // collect output words and check that done_compute follows the last one
    always @(negedge clk) begin
        if (arst_n) begin
            if (ofm_valid) begin
                got_data.push_back(ofm_data);
                got_index.push_back(ofm_index);
            end
            if (done_compute) begin
                done_count++;
                done_size = got_data.size();
                check_value("ofm_valid before done_compute", prev_valid, 1'b1);
            end
            prev_valid = ofm_valid;
        end
    end

    initial begin
        integer        fd;
        integer        rc;
        logic [63:0]   kind;
        logic [1023:0] line;
        logic [2:0]    op;
        logic [10:0]   addr;
        logic [31:0]   data;
        logic [6:0]    idx;
        logic          stop;
        clk        = 1'b0;
        arst_n     = 1'b0;
        cmd        = '0;
        cmd_valid  = 1'b0;
        prev_valid = 1'b0;
        stop       = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        check_value("ofm_valid", ofm_valid, 1'b0);
        check_value("done_compute", done_compute, 1'b0);
        fd = $fopen("sim/conv_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open sim/conv_patterns.txt");
            stop = 1'b1;
        end
        while (!stop && $fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                rc = $fgets(line, fd);
            end else if (kind == "C") begin
                rc = $fscanf(fd, "%h %h %h", op, addr, data);
                if (rc != 3) begin
                    other_errors++;
                    $display("malformed command record in the pattern file");
                    stop = 1'b1;
                end else begin
                    send_cmd(op, addr, data);
                end
            end else if (kind == "E") begin
                rc = $fscanf(fd, "%h %h", idx, data);
                if (rc != 2) begin
                    other_errors++;
                    $display("malformed expect record in the pattern file");
                    stop = 1'b1;
                end else begin
                    exp_index.push_back(idx);
                    exp_data.push_back(data);
                end
            end else if (kind == "W") begin
                runs++;
                wait_done(stop);
                if (!stop) begin
                    compare_run();
                end
            end else begin
                other_errors++;
                $display("unknown record %0s in the pattern file", kind);
                stop = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (runs == 0) begin
            other_errors++;
            $display("the pattern file held no run");
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim/conv_props.sv
`timescale 1ns/10ps

module conv_props (
    input logic clk,
    input logic arst_n,
    input logic ofm_valid,
    input logic busy,
    input logic done_compute
);

    // strobes stay quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !ofm_valid && !done_compute)
        else $error("ofm_valid or done_compute high during reset");

    a_done_single: assert property (@(posedge clk) disable iff (!arst_n)
        done_compute |=> !done_compute)
        else $error("done_compute longer than one cycle");

    a_valid_busy: assert property (@(posedge clk) disable iff (!arst_n)
        ofm_valid |-> busy)
        else $error("ofm_valid while not busy");

    // busy drops on the edge right after done_compute
    a_done_busy: assert property (@(posedge clk) disable iff (!arst_n)
        done_compute |-> busy ##1 !busy)
        else $error("busy did not drop after done_compute");

    a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(done_compute))
        else $error("busy fell without done_compute");

endmodule

bind conv_top conv_props u_props (
    .clk          (clk),
    .arst_n       (arst_n),
    .ofm_valid    (ofm_valid),
    .busy         (busy),
    .done_compute (done_compute)
);

//--- src/conv_top.sv
`timescale 1ns/10ps

module conv_top (
    input  logic                clk,
    input  logic                arst_n,
    input  conv_pkg::cmd_t      cmd,
    input  logic                cmd_valid,
    output logic                ofm_valid,
    output conv_pkg::ofm_word_t ofm_data,
    output logic [6:0]          ofm_index,
    output logic                busy,
    output logic                done_compute
);
    import conv_pkg::*;

    logic                           ifm_we;
    logic [NUM_PE-1:0]              weight_we;
    logic [BUF_AW-1:0]              wr_addr;
    logic [DATA_W-1:0]              wr_data;
    shape_t                         shape;
    logic                           start;
    logic [BUF_AW-1:0]              ifm_rd_addr;
    logic [KMAX_AW-1:0]             w_rd_addr;
    logic [DATA_W-1:0]              ifm_word;
    logic [NUM_PE-1:0][DATA_W-1:0]  weight_words;
    rd_tag_t                        tag;
    logic                           tag_valid;
    acc_word_t                      sums;
    logic                           sum_valid;
    logic [6:0]                     sum_index;

    conv_decode u_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .done_compute (done_compute),
        .ifm_we       (ifm_we),
        .weight_we    (weight_we),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .shape        (shape),
        .start        (start),
        .busy         (busy)
    );

    conv_buffers u_buffers (
        .clk          (clk),
        .ifm_we       (ifm_we),
        .weight_we    (weight_we),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .ifm_rd_addr  (ifm_rd_addr),
        .w_rd_addr    (w_rd_addr),
        .ifm_word     (ifm_word),
        .weight_words (weight_words)
    );

    conv_addr_gen u_addr_gen (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .shape        (shape),
        .ifm_rd_addr  (ifm_rd_addr),
        .w_rd_addr    (w_rd_addr),
        .tag          (tag),
        .tag_valid    (tag_valid),
        .done_compute (done_compute)
    );

    conv_pe_array u_pe_array (
        .clk          (clk),
        .arst_n       (arst_n),
        .ifm_word     (ifm_word),
        .weight_words (weight_words),
        .tag          (tag),
        .tag_valid    (tag_valid),
        .sums         (sums),
        .sum_valid    (sum_valid),
        .sum_index    (sum_index)
    );

    conv_result u_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .sums         (sums),
        .sum_valid    (sum_valid),
        .sum_index    (sum_index),
        .ofm_valid    (ofm_valid),
        .ofm_data     (ofm_data),
        .ofm_index    (ofm_index)
    );

endmodule

//--- src/conv_result.sv
`timescale 1ns/10ps

module conv_result (
    input  logic                 clk,
    input  logic                 arst_n,
    input  conv_pkg::acc_word_t  sums,
    input  logic                 sum_valid,
    input  logic [6:0]           sum_index,
    output logic                 ofm_valid,
    output conv_pkg::ofm_word_t  ofm_data,
    output logic [6:0]           ofm_index
);
    import conv_pkg::*;

    ofm_word_t packed_word;

    always_comb begin : p_clamp
        logic signed [ACC_W-1:0] scaled;
        for (int f = 0; f < NUM_PE; f++) begin
            scaled = $signed(sums[f]) >>> QUANT_SHIFT;
            // relu6 in Q4
            if (scaled < 0) begin
                packed_word[f] = '0;
            end else if (scaled > RELU6_CAP) begin
                packed_word[f] = LANE_W'(RELU6_CAP);
            end else begin
                packed_word[f] = scaled[LANE_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            ofm_data  <= packed_word;
            ofm_index <= sum_index;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ofm_valid <= 1'b0;
        end else begin
            ofm_valid <= sum_valid;
        end
    end

endmodule

//--- src/conv_pe_array.sv
`timescale 1ns/10ps

module conv_pe_array (
    input  logic                                             clk,
    input  logic                                             arst_n,
    input  logic [conv_pkg::DATA_W-1:0]                      ifm_word,
    input  logic [conv_pkg::NUM_PE-1:0][conv_pkg::DATA_W-1:0] weight_words,
    input  conv_pkg::rd_tag_t                                tag,
    input  logic                                             tag_valid,
    output conv_pkg::acc_word_t                              sums,
    output logic                                             sum_valid,
    output logic [6:0]                                       sum_index
);
    import conv_pkg::*;

    acc_word_t acc;
    acc_word_t acc_nxt;

    // signed int8 dot product over the packed lanes
    function automatic logic signed [ACC_W-1:0] dot4(input logic [DATA_W-1:0] a,
                                                     input logic [DATA_W-1:0] b);
        logic signed [ACC_W-1:0]    s;
        logic signed [2*LANE_W-1:0] p;
        s = '0;
        for (int l = 0; l < LANES; l++) begin
            p = $signed(a[l*LANE_W +: LANE_W]) * $signed(b[l*LANE_W +: LANE_W]);
            s = s + p;
        end
        return s;
    endfunction

    always_comb begin
        for (int f = 0; f < NUM_PE; f++) begin
            if (tag.first) begin
                acc_nxt[f] = dot4(ifm_word, weight_words[f]);
            end else begin
                acc_nxt[f] = acc[f] + dot4(ifm_word, weight_words[f]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_valid) begin
            acc <= acc_nxt;
            if (tag.last) begin
                sums      <= acc_nxt;
                sum_index <= tag.index;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= tag_valid && tag.last;
        end
    end

endmodule

//--- src/conv_addr_gen.sv
`timescale 1ns/10ps

module conv_addr_gen (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start,
    input  conv_pkg::shape_t              shape,
    output logic [conv_pkg::BUF_AW-1:0]   ifm_rd_addr,
    output logic [conv_pkg::KMAX_AW-1:0]  w_rd_addr,
    output conv_pkg::rd_tag_t             tag,
    output logic                          tag_valid,
    output logic                          done_compute
);
    import conv_pkg::*;

    logic              running;
    logic [7:0]        win;
    logic [3:0]        k;
    logic [BUF_AW-1:0] base;
    logic              last_k;
    logic              last_win;
    rd_tag_t           issue;
    logic              issue_valid;
    logic              issue_final;
    // tag, sum, result, then done
    logic [3:0]        fin_q;

    assign last_k   = (k == shape.kernel_w - 4'd1);
    assign last_win = (win == shape.ofm_w - 8'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running     <= 1'b0;
            win         <= '0;
            k           <= '0;
            base        <= '0;
            issue_valid <= 1'b0;
            issue_final <= 1'b0;
            tag_valid   <= 1'b0;
            fin_q       <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
                win     <= '0;
                k       <= '0;
                base    <= '0;
            end else if (running) begin
                if (last_k) begin
                    k    <= '0;
                    win  <= win + 8'd1;
                    base <= base + BUF_AW'(shape.stride);
                    if (last_win) begin
                        running <= 1'b0;
                    end
                end else begin
                    k <= k + 4'd1;
                end
            end
            issue_valid <= running;
            issue_final <= running && last_k && last_win;
            // data comes back one cycle after the address
            tag_valid   <= issue_valid;
            fin_q       <= {fin_q[2:0], issue_final};
        end
    end

    always_ff @(posedge clk) begin
        issue.ifm_addr <= base + BUF_AW'(k);
        issue.w_addr   <= k[KMAX_AW-1:0];
        issue.first    <= (k == 4'd0);
        issue.last     <= last_k;
        issue.index    <= win[6:0];
        tag            <= issue;
    end

    assign ifm_rd_addr  = issue.ifm_addr;
    assign w_rd_addr    = issue.w_addr;
    assign done_compute = fin_q[3];

endmodule

//--- src/conv_buffers.sv
`timescale 1ns/10ps

module conv_buffers (
    input  logic                                             clk,
    input  logic                                             ifm_we,
    input  logic [conv_pkg::NUM_PE-1:0]                      weight_we,
    input  logic [conv_pkg::BUF_AW-1:0]                      wr_addr,
    input  logic [conv_pkg::DATA_W-1:0]                      wr_data,
    input  logic [conv_pkg::BUF_AW-1:0]                      ifm_rd_addr,
    input  logic [conv_pkg::KMAX_AW-1:0]                     w_rd_addr,
    output logic [conv_pkg::DATA_W-1:0]                      ifm_word,
    output logic [conv_pkg::NUM_PE-1:0][conv_pkg::DATA_W-1:0] weight_words
);
    import conv_pkg::*;

    localparam int IFM_DEPTH = 2 ** BUF_AW;

    logic [DATA_W-1:0] ifm_mem [IFM_DEPTH];

    always_ff @(posedge clk) begin
        if (ifm_we) begin
            ifm_mem[wr_addr] <= wr_data;
        end
        ifm_word <= ifm_mem[ifm_rd_addr];
    end

    // one bank per PE, all read at the same kernel tap
    for (genvar f = 0; f < NUM_PE; f++) begin : g_bank
        logic [DATA_W-1:0] w_mem [KMAX];

        always_ff @(posedge clk) begin
            if (weight_we[f]) begin
                w_mem[wr_addr[KMAX_AW-1:0]] <= wr_data;
            end
            weight_words[f] <= w_mem[w_rd_addr];
        end
    end

endmodule

//--- src/conv_decode.sv
`timescale 1ns/10ps

module conv_decode (
    input  logic                              clk,
    input  logic                              arst_n,
    input  conv_pkg::cmd_t                    cmd,
    input  logic                              cmd_valid,
    input  logic                              done_compute,
    output logic                              ifm_we,
    output logic [conv_pkg::NUM_PE-1:0]       weight_we,
    output logic [conv_pkg::BUF_AW-1:0]       wr_addr,
    output logic [conv_pkg::DATA_W-1:0]       wr_data,
    output conv_pkg::shape_t                  shape,
    output logic                              start,
    output logic                              busy
);
    import conv_pkg::*;

    logic              cmd_ok;
    logic [BANK_W-1:0] bank;

    // nothing gets through while a run is active
    assign cmd_ok = cmd_valid && !busy;
    assign bank   = cmd.addr[BUF_AW +: BANK_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ifm_we    <= 1'b0;
            weight_we <= '0;
            start     <= 1'b0;
            busy      <= 1'b0;
            shape     <= '0;
        end else begin
            ifm_we    <= 1'b0;
            weight_we <= '0;
            start     <= 1'b0;
            if (done_compute) begin
                busy <= 1'b0;
            end
            if (cmd_ok) begin
                case (cmd.opcode)
                    op_wr_ifm: begin
                        ifm_we <= 1'b1;
                    end
                    op_wr_weight: begin
                        weight_we <= NUM_PE'(1) << bank;
                    end
                    op_set_shape: begin
                        shape <= shape_t'(cmd.data[$bits(shape_t)-1:0]);
                    end
                    op_start: begin
                        start <= 1'b1;
                        busy  <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // write payload follows the strobes by the same one cycle
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            wr_addr <= cmd.addr[BUF_AW-1:0];
            wr_data <= cmd.data;
        end
    end

endmodule

//--- src/conv_pkg.sv
package conv_pkg;

    localparam int DATA_W      = 32;
    localparam int LANES       = 4;
    localparam int LANE_W      = DATA_W / LANES;
    localparam int NUM_PE      = 4;
    localparam int BANK_W      = $clog2(NUM_PE);
    localparam int BUF_AW      = 6;
    localparam int KMAX        = 8;
    localparam int KMAX_AW     = $clog2(KMAX);
    localparam int ACC_W       = 22;
    localparam int QUANT_SHIFT = 4;
    // 6.0 in Q4
    localparam int RELU6_CAP   = 96;

    typedef enum logic [2:0] {
        op_nop       = 3'd0,
        op_wr_ifm    = 3'd1,
        op_wr_weight = 3'd2,
        op_set_shape = 3'd3,
        op_start     = 3'd4
    } opcode_e;

    // addr[BUF_AW-1:0] word address, addr[BUF_AW +: BANK_W] weight bank
    typedef struct packed {
        opcode_e             opcode;
        logic [10:0]         addr;
        logic [DATA_W-1:0]   data;
    } cmd_t;

    typedef struct packed {
        logic [3:0] kernel_w;
        logic [7:0] ofm_w;
        logic [1:0] stride;
    } shape_t;

    typedef struct packed {
        logic [BUF_AW-1:0]  ifm_addr;
        logic [KMAX_AW-1:0] w_addr;
        logic               first;
        logic               last;
        logic [6:0]         index;
    } rd_tag_t;

    typedef logic [NUM_PE-1:0][ACC_W-1:0]  acc_word_t;
    typedef logic [NUM_PE-1:0][LANE_W-1:0] ofm_word_t;

endpackage
